// ==== rtl/rv_mem_pkg.sv ====
package rv_mem_pkg;

    localparam int xlen = 64;
    localparam int id_w = 4;

    localparam logic [id_w-1:0] id_fetch = 4'd1;
    localparam logic [id_w-1:0] id_mem   = 4'd2;

    localparam int ram_words = 64;
    localparam int ram_lat   = 2;                   // address accept to response
    localparam int ram_aw    = $clog2(ram_words);   // doubleword index width
    localparam int lat_w     = $clog2(ram_lat + 1);

    // riscv funct3 order
    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        ld  = 3'd3,
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6
    } load_kind_e;

    typedef struct packed {
        logic            valid;
        logic            is_load;
        load_kind_e      kind;
        logic [4:0]      rd;
        logic [xlen-1:0] base;
        logic [xlen-1:0] offset;
        logic [xlen-1:0] alu_res;   // result for non-load ops
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [id_w-1:0] id;
    } rd_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
        logic [id_w-1:0] id;
    } rd_rsp_t;

    // one read word seen as a whole or as its lanes
    typedef union packed {
        logic [xlen-1:0]  dw;
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
    } rd_word_u;

endpackage

// ==== rtl/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic [rv_mem_pkg::xlen-1:0] word,
    input  logic [2:0]                  addr_lo,
    input  rv_mem_pkg::load_kind_e      kind,
    output logic [rv_mem_pkg::xlen-1:0] data
);

    rv_mem_pkg::rd_word_u lanes;
    logic [7:0]           byte_v;
    logic [15:0]          half_v;
    logic [31:0]          word_v;

    assign lanes = word;

    // lane picks, low address bits taken as aligned
    assign byte_v = lanes.b[addr_lo];
    assign half_v = lanes.h[addr_lo[2:1]];
    assign word_v = lanes.w[addr_lo[2]];

    always_comb begin
        case (kind)
            rv_mem_pkg::lb: begin
                data = {{(rv_mem_pkg::xlen - 8){byte_v[7]}}, byte_v};
            end
            rv_mem_pkg::lbu: begin
                data = {{(rv_mem_pkg::xlen - 8){1'b0}}, byte_v};
            end
            rv_mem_pkg::lh: begin
                data = {{(rv_mem_pkg::xlen - 16){half_v[15]}}, half_v};
            end
            rv_mem_pkg::lhu: begin
                data = {{(rv_mem_pkg::xlen - 16){1'b0}}, half_v};
            end
            rv_mem_pkg::lw: begin
                data = {{(rv_mem_pkg::xlen - 32){word_v[31]}}, word_v};
            end
            rv_mem_pkg::lwu: begin
                data = {{(rv_mem_pkg::xlen - 32){1'b0}}, word_v};
            end
            default: begin
                data = lanes.dw;   // ld
            end
        endcase
    end

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_mem_pkg::ex_mem_t ex_in,
    input  logic                mem_ar_ready,
    input  rv_mem_pkg::rd_rsp_t mem_rsp,
    output logic                ex_ready,
    output rv_mem_pkg::rd_req_t mem_req,
    output rv_mem_pkg::wb_t     wb_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait,
        st_fin
    } state_e;

    state_e                      state;
    state_e                      state_nxt;
    logic                        accept;
    logic                        rsp_hit;
    logic [rv_mem_pkg::xlen-1:0] ld_addr;
    rv_mem_pkg::load_kind_e      ld_kind;
    logic [4:0]                  ld_rd;
    logic [rv_mem_pkg::xlen-1:0] ld_data;
    logic                        wb_valid;
    logic [4:0]                  wb_rd;
    logic [rv_mem_pkg::xlen-1:0] wb_data;

    // st_fin is the writeback cycle of a load, new op may be taken there
    assign ex_ready = (state == st_idle) || (state == st_fin);
    assign accept   = ex_in.valid && ex_ready;
    assign rsp_hit  = (state == st_wait) && mem_rsp.valid && (mem_rsp.id == rv_mem_pkg::id_mem);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle, st_fin: begin
                if (accept && ex_in.is_load)
                    state_nxt = st_req;
                else
                    state_nxt = st_idle;
            end
            st_req: begin
                if (mem_ar_ready)
                    state_nxt = st_wait;   // address taken by arbiter
            end
            st_wait: begin
                if (rsp_hit)
                    state_nxt = st_fin;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    // load info, held stable while the request waits for a grant
    always_ff @(posedge clk) begin
        if (accept && ex_in.is_load) begin
            ld_addr <= ex_in.base + ex_in.offset;
            ld_kind <= ex_in.kind;
            ld_rd   <= ex_in.rd;
        end
    end

    assign mem_req = '{valid: (state == st_req), addr: ld_addr, id: rv_mem_pkg::id_mem};

    load_align u_align (
        .word    (mem_rsp.data),
        .addr_lo (ld_addr[2:0]),
        .kind    (ld_kind),
        .data    (ld_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= (accept && !ex_in.is_load) || rsp_hit;
    end

    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            wb_rd   <= ld_rd;
            wb_data <= ld_data;
        end else if (accept && !ex_in.is_load) begin
            wb_rd   <= ex_in.rd;
            wb_data <= ex_in.alu_res;   // straight passthrough
        end
    end

    assign wb_out = '{valid: wb_valid, rd: wb_rd, data: wb_data};

    // a response for this stage means its load is still outstanding
    a_no_accept_in_flight: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_rsp.valid && (mem_rsp.id == rv_mem_pkg::id_mem)) |-> !accept
    ) else $error("operation accepted while a load is outstanding");

endmodule

// ==== rtl/rd_arbiter.sv ====
`timescale 1ns/1ps

module rd_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_mem_pkg::rd_req_t mem_req,
    input  rv_mem_pkg::rd_req_t fetch_req,
    input  logic                ram_ar_ready,
    input  rv_mem_pkg::rd_rsp_t ram_rsp,
    output logic                mem_ar_ready,
    output logic                fetch_ar_ready,
    output rv_mem_pkg::rd_req_t ram_req,
    output rv_mem_pkg::rd_rsp_t mem_rsp,
    output rv_mem_pkg::rd_rsp_t fetch_rsp
);

    logic                        busy;      // one transaction in flight
    logic [rv_mem_pkg::id_w-1:0] gnt_id;
    logic                        ram_hs;

    // memory stage wins on a tie
    assign ram_req.valid = !busy && (mem_req.valid || fetch_req.valid);
    assign ram_req.addr  = mem_req.valid ? mem_req.addr : fetch_req.addr;
    assign ram_req.id    = mem_req.valid ? rv_mem_pkg::id_mem : rv_mem_pkg::id_fetch;

    assign mem_ar_ready   = !busy && ram_ar_ready;
    assign fetch_ar_ready = !busy && ram_ar_ready && !mem_req.valid;

    assign ram_hs = ram_req.valid && ram_ar_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            gnt_id <= '0;
        end else begin
            if (ram_hs) begin
                busy   <= 1'b1;
                gnt_id <= ram_req.id;
            end else if (ram_rsp.valid) begin
                busy <= 1'b0;
            end
        end
    end

    // route by tag
    always_comb begin
        mem_rsp         = ram_rsp;
        fetch_rsp       = ram_rsp;
        mem_rsp.valid   = ram_rsp.valid && (ram_rsp.id == rv_mem_pkg::id_mem);
        fetch_rsp.valid = ram_rsp.valid && (ram_rsp.id == rv_mem_pkg::id_fetch);
    end

    a_rsp_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_rsp.valid |-> busy
    ) else $error("read response with no transaction outstanding");

    a_rsp_id_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_rsp.valid |-> (ram_rsp.id == gnt_id)
    ) else $error("response id %0d does not match grant %0d", ram_rsp.id, gnt_id);

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_mem_pkg::rd_req_t req,
    output logic                ar_ready,
    output rv_mem_pkg::rd_rsp_t rsp
);

    logic [rv_mem_pkg::xlen-1:0]   mem [rv_mem_pkg::ram_words];
    logic                          busy;
    logic [rv_mem_pkg::lat_w-1:0]  cnt;    // cycles left before the answer
    logic [rv_mem_pkg::ram_aw-1:0] idx_q;
    logic [rv_mem_pkg::id_w-1:0]   id_q;
    logic                          accept;

    initial begin
        $readmemh("mem_init.hex", mem);
    end

    assign ar_ready = !busy;
    assign accept   = req.valid && ar_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
                cnt  <= rv_mem_pkg::lat_w'(rv_mem_pkg::ram_lat - 1);
            end else if (busy) begin
                if (cnt == '0)
                    busy <= 1'b0;   // answer went out this cycle
                else
                    cnt <= cnt - 1'b1;
            end
        end
    end

    // doubleword index from addr bits above bit 2
    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q <= req.addr[rv_mem_pkg::ram_aw+2:3];
            id_q  <= req.id;
        end
    end

    assign rsp.valid = busy && (cnt == '0);
    assign rsp.data  = mem[idx_q];
    assign rsp.id    = id_q;

    a_rsp_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.valid |=> !rsp.valid
    ) else $error("response valid held past one cycle");

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_mem_pkg::ex_mem_t ex_in,
    input  rv_mem_pkg::rd_req_t fetch_req,
    output logic                ex_ready,
    output rv_mem_pkg::wb_t     wb_out,
    output logic                fetch_ar_ready,
    output rv_mem_pkg::rd_rsp_t fetch_rsp
);

    rv_mem_pkg::rd_req_t mem_req;
    logic                mem_ar_ready;
    rv_mem_pkg::rd_rsp_t mem_rsp;
    rv_mem_pkg::rd_req_t ram_req;
    logic                ram_ar_ready;
    rv_mem_pkg::rd_rsp_t ram_rsp;

    mem_stage u_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_in        (ex_in),
        .mem_ar_ready (mem_ar_ready),
        .mem_rsp      (mem_rsp),
        .ex_ready     (ex_ready),
        .mem_req      (mem_req),
        .wb_out       (wb_out)
    );

    rd_arbiter u_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .fetch_req      (fetch_req),
        .ram_ar_ready   (ram_ar_ready),
        .ram_rsp        (ram_rsp),
        .mem_ar_ready   (mem_ar_ready),
        .fetch_ar_ready (fetch_ar_ready),
        .ram_req        (ram_req),
        .mem_rsp        (mem_rsp),
        .fetch_rsp      (fetch_rsp)
    );

    data_ram u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (ram_req),
        .ar_ready (ram_ar_ready),
        .rsp      (ram_rsp)
    );

endmodule

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int max_cycles = 4000;   // full run is near 800 cycles

    logic                        clk;
    logic                        rst_n;
    rv_mem_pkg::ex_mem_t         ex_in;
    rv_mem_pkg::rd_req_t         fetch_req;
    logic                        ex_ready;
    rv_mem_pkg::wb_t             wb_out;
    logic                        fetch_ar_ready;
    rv_mem_pkg::rd_rsp_t         fetch_rsp;

    logic [rv_mem_pkg::xlen-1:0] mem_img [rv_mem_pkg::ram_words];
    logic [31:0]                 rng;
    int                          cycles = 0;
    int                          errors = 0;
    int                          checks = 0;
    int                          tests = 0;
    int                          test_err0;
    string                       cur_test = "reset";
    logic [4:0]                  exp_rd_q [$];     // writebacks still owed, in issue order
    logic [rv_mem_pkg::xlen-1:0] exp_data_q [$];
    logic                        fetch_busy;
    logic [rv_mem_pkg::xlen-1:0] fetch_exp;
    logic                        load_pending;

    mem_subsys_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_in          (ex_in),
        .fetch_req      (fetch_req),
        .ex_ready       (ex_ready),
        .wb_out         (wb_out),
        .fetch_ar_ready (fetch_ar_ready),
        .fetch_rsp      (fetch_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run still busy after %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // reference lane pick, shift the lane down then extend
    function automatic logic [63:0] expect_load(input logic [63:0] dw, input logic [2:0] lo,
                                                input rv_mem_pkg::load_kind_e kind);
        logic [63:0] sh;
        sh = dw >> {lo, 3'b000};
        case (kind)
            rv_mem_pkg::lb:  return {{56{sh[7]}}, sh[7:0]};
            rv_mem_pkg::lh:  return {{48{sh[15]}}, sh[15:0]};
            rv_mem_pkg::lw:  return {{32{sh[31]}}, sh[31:0]};
            rv_mem_pkg::lbu: return {56'd0, sh[7:0]};
            rv_mem_pkg::lhu: return {48'd0, sh[15:0]};
            rv_mem_pkg::lwu: return {32'd0, sh[31:0]};
            default:         return dw;
        endcase
    endfunction

    function automatic logic [63:0] rand_addr(input rv_mem_pkg::load_kind_e kind);
        logic [63:0] a;
        logic [2:0]  k;
        k = kind;
        a = {next_rand(), next_rand()};
        a = a & ~((64'd1 << k[1:0]) - 64'd1);   // funct3 low bits = log2 size
        return a;
    endfunction

    function automatic rv_mem_pkg::ex_mem_t make_load(input rv_mem_pkg::load_kind_e kind,
                                                      input logic [4:0] rd,
                                                      input logic [63:0] addr);
        rv_mem_pkg::ex_mem_t op;
        op         = '0;
        op.valid   = 1'b1;
        op.is_load = 1'b1;
        op.kind    = kind;
        op.rd      = rd;
        op.base    = {next_rand(), next_rand()};
        op.offset  = addr - op.base;              // random split of the same address
        op.alu_res = {next_rand(), next_rand()};  // junk, must not reach writeback
        return op;
    endfunction

    function automatic rv_mem_pkg::ex_mem_t make_alu(input logic [4:0] rd);
        rv_mem_pkg::ex_mem_t op;
        op         = '0;
        op.valid   = 1'b1;
        op.rd      = rd;
        op.alu_res = {next_rand(), next_rand()};
        return op;
    endfunction

    // returns 1 ns after the edge that took the op
    task automatic issue(input rv_mem_pkg::ex_mem_t op);
        logic [63:0] a;
        a     = op.base + op.offset;
        ex_in = op;
        exp_rd_q.push_back(op.rd);
        if (op.is_load)
            exp_data_q.push_back(expect_load(mem_img[a[8:3]], a[2:0], op.kind));
        else
            exp_data_q.push_back(op.alu_res);
        while (!ex_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        ex_in.valid = 1'b0;
    endtask

    task automatic fetch_read(input logic [63:0] addr);
        fetch_req.valid = 1'b1;
        fetch_req.addr  = addr;
        fetch_req.id    = rv_mem_pkg::id_fetch;
        fetch_exp       = mem_img[addr[8:3]];   // fetch sees the raw doubleword
        fetch_busy      = 1'b1;
        while (!fetch_ar_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_rd_q.size() != 0 || fetch_busy) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_err0)
            $display("test %-12s ok", cur_test);
        else
            $display("test %-12s %0d errors", cur_test, errors - test_err0);
    endtask

    // outputs are registered, mid-cycle is a safe place to look
    always @(negedge clk) begin : monitor
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        if (rst_n && wb_out.valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("%s: writeback pulse with no operation outstanding", cur_test);
                errors++;
            end else begin
                e_rd   = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                checks++;
                assert (wb_out.rd == e_rd && wb_out.data == e_data) else begin
                    $display("[FAIL] %s: expected rd %0d data %h, actual rd %0d data %h",
                             cur_test, e_rd, e_data, wb_out.rd, wb_out.data);
                    errors++;
                end
            end
        end
        if (rst_n && fetch_rsp.valid) begin
            if (!fetch_busy) begin
                $display("%s: fetch response with no fetch outstanding", cur_test);
                errors++;
            end else begin
                checks++;
                assert (fetch_rsp.data == fetch_exp) else begin
                    $display("[FAIL] %s: expected fetch data %h, actual %h",
                             cur_test, fetch_exp, fetch_rsp.data);
                    errors++;
                end
                fetch_busy = 1'b0;
            end
        end
    end

    // set when a load is taken, cleared by the first writeback after it
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            load_pending <= 1'b0;
        else if (ex_in.valid && ex_ready && ex_in.is_load)
            load_pending <= 1'b1;
        else if (wb_out.valid)
            load_pending <= 1'b0;
    end

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |-> (ex_ready && !wb_out.valid && !fetch_rsp.valid))
        else begin
            $display("%s: outputs not idle while reset is held", cur_test);
            errors++;
        end

    a_alu_next: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_in.valid && ex_ready && !ex_in.is_load) |=> wb_out.valid)
        else begin
            $display("%s: no writeback in the cycle after a non-load", cur_test);
            errors++;
        end

    // execute held off until the load's own pulse
    a_load_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (load_pending && !wb_out.valid) |-> !ex_ready)
        else begin
            $display("%s: execute not stalled while a load is outstanding", cur_test);
            errors++;
        end

    a_fetch_id: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.valid |-> (fetch_rsp.id == rv_mem_pkg::id_fetch))
        else begin
            $display("%s: fetch port got a response tagged for another master", cur_test);
            errors++;
        end

    initial begin : stimulus
        rv_mem_pkg::load_kind_e kind;
        logic [63:0]            addr;
        logic [31:0]            r;
        logic [2:0]             kb;
        int                     n;
        rng        = 32'h174a;
        rst_n      = 1'b0;
        ex_in      = '0;
        fetch_req  = '0;
        fetch_busy = 1'b0;
        fetch_exp  = '0;
        n          = 0;
        $readmemh("mem_init.hex", mem_img);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("reset");
        checks++;
        assert (ex_ready && !wb_out.valid && !fetch_rsp.valid) else begin
            $display("%s: outputs not idle after reset release", cur_test);
            errors++;
        end
        end_test();

        begin_test("passthrough");
        for (int i = 0; i < 12; i++)
            issue(make_alu(5'(i + 1)));
        drain();
        end_test();

        begin_test("load_lanes");
        for (int k = 0; k < 7; k++) begin
            kind = rv_mem_pkg::load_kind_e'(k);
            kb   = 3'(k);
            for (int lo = 0; lo < 8; lo += (1 << kb[1:0])) begin
                addr      = {next_rand(), next_rand()};
                addr[2:0] = 3'(lo);
                issue(make_load(kind, 5'(n % 31 + 1), addr));
                n++;
            end
        end
        drain();
        end_test();

        begin_test("stall");
        for (int i = 0; i < 4; i++) begin
            issue(make_load(rv_mem_pkg::lw, 5'(i + 3), rand_addr(rv_mem_pkg::lw)));
            issue(make_alu(5'(i + 10)));   // waits on ex_ready behind the load
            issue(make_alu(5'(i + 20)));
        end
        drain();
        end_test();

        begin_test("contention");
        for (int i = 0; i < 6; i++) begin
            issue(make_load(rv_mem_pkg::ld, 5'(i + 1), rand_addr(rv_mem_pkg::ld)));
            fetch_read(rand_addr(rv_mem_pkg::ld));   // same cycle as the load request
            drain();
        end
        end_test();

        begin_test("random");
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            if (r[0]) begin
                kind = rv_mem_pkg::load_kind_e'(r[10:8] % 3'd7);
                issue(make_load(kind, r[15:11], rand_addr(kind)));
            end else begin
                issue(make_alu(r[15:11]));
            end
        end
        drain();
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/rv_mem_pkg.sv
rtl/load_align.sv
rtl/mem_stage.sv
rtl/rd_arbiter.sv
rtl/data_ram.sv
rtl/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// ==== Makefile ====
TOP := tb_mem_subsys

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

obj_dir/V$(TOP): verilog.f $(wildcard rtl/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
		-f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall \
		-f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== mem_init.hex ====
// one doubleword per line, index 0 to 63; byte k of index i is {k, i[4:0]} ^ {i[5], 7'b0}
e0c0a08060402000
e1c1a18161412101
e2c2a28262422202
e3c3a38363432303
e4c4a48464442404
e5c5a58565452505
e6c6a68666462606
e7c7a78767472707
e8c8a88868482808
e9c9a98969492909
eacaaa8a6a4a2a0a
ebcbab8b6b4b2b0b
ecccac8c6c4c2c0c
edcdad8d6d4d2d0d
eeceae8e6e4e2e0e
efcfaf8f6f4f2f0f
f0d0b09070503010
f1d1b19171513111
f2d2b29272523212
f3d3b39373533313
f4d4b49474543414
f5d5b59575553515
f6d6b69676563616
f7d7b79777573717
f8d8b89878583818
f9d9b99979593919
fadaba9a7a5a3a1a
fbdbbb9b7b5b3b1b
fcdcbc9c7c5c3c1c
fdddbd9d7d5d3d1d
fedebe9e7e5e3e1e
ffdfbf9f7f5f3f1f
60402000e0c0a080
61412101e1c1a181
62422202e2c2a282
63432303e3c3a383
64442404e4c4a484
65452505e5c5a585
66462606e6c6a686
67472707e7c7a787
68482808e8c8a888
69492909e9c9a989
6a4a2a0aeacaaa8a
6b4b2b0bebcbab8b
6c4c2c0cecccac8c
6d4d2d0dedcdad8d
6e4e2e0eeeceae8e
6f4f2f0fefcfaf8f
70503010f0d0b090
71513111f1d1b191
72523212f2d2b292
73533313f3d3b393
74543414f4d4b494
75553515f5d5b595
76563616f6d6b696
77573717f7d7b797
78583818f8d8b898
79593919f9d9b999
7a5a3a1afadaba9a
7b5b3b1bfbdbbb9b
7c5c3c1cfcdcbc9c
7d5d3d1dfdddbd9d
7e5e3e1efedebe9e
7f5f3f1fffdfbf9f
